/* filelist.f */
source/core_pkg.sv
source/decode_stage.sv
source/data_select_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/write_back_stage.sv
source/core.sv
dv/core_chk.sv
dv/core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module core_tb \
    -o sim_core_tb > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_core_tb > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "simulator exited with an error" sim.log && exit 1
exit 0

/* dv/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

    logic clk;
    logic reset;
    core_pkg::fetch_resp_t iresp;
    logic iresp_ready;
    core_pkg::fetch_req_t ireq;
    core_pkg::mem_req_t dreq;
    core_pkg::mem_resp_t dresp;
    core_pkg::word_t gp;
    logic exit;

    core_pkg::word_t imem [0:255];
    core_pkg::word_t dmem [0:255];
    core_pkg::mem_req_t stores [$];
    core_pkg::mem_req_t ref_stores [$];
    core_pkg::word_t fetch_pc;
    // separate streams for fetch gaps and memory latency
    core_pkg::word_t gap_lcg;
    core_pkg::word_t mem_lcg;
    logic gaps_on;
    logic mem_random;
    logic mem_busy;
    int mem_wait;
    int load_idx;

    core core_inst (
        .clk         (clk),
        .reset       (reset),
        .iresp       (iresp),
        .iresp_ready (iresp_ready),
        .ireq        (ireq),
        .dreq        (dreq),
        .dresp       (dresp),
        .gp          (gp),
        .exit        (exit)
    );

    always #10 clk = ~clk;

    // upper bits, the low bits of this lcg repeat every few steps
    function automatic core_pkg::word_t next_rand(inout core_pkg::word_t state);
        state = state * 32'd1103515245 + 32'd12345;
        return state >> 16;
    endfunction

    // memory fill from the full byte address
    function automatic core_pkg::word_t fill_value(input core_pkg::word_t addr);
        return addr * 32'h9e37_79b9 + 32'h0123_4567;
    endfunction

    // instruction queue model
    always @(posedge clk) begin
        logic in_reset;
        logic taken;
        logic redirect;
        core_pkg::word_t target;
        in_reset = reset;
        taken = iresp.valid && iresp_ready;
        redirect = ireq.valid;
        target = ireq.addr;
        #1;
        if (in_reset) begin
            fetch_pc = core_pkg::reset_pc;
        end else if (redirect) begin
            fetch_pc = target;
        end else if (taken) begin
            fetch_pc = fetch_pc + 32'd4;
        end
        iresp.addr = fetch_pc;
        iresp.inst = imem[fetch_pc[9:2]];
        iresp.valid = !in_reset && !(gaps_on && next_rand(gap_lcg) % 4 == 0);
    end

    // data memory model, latency 0 to 3 extra cycles
    always @(posedge clk) begin
        logic in_reset;
        core_pkg::mem_req_t req;
        logic consumed;
        in_reset = reset;
        req = dreq;
        consumed = dresp.valid;
        #1;
        dresp.valid = 1'b0;
        if (in_reset) begin
            mem_busy = 1'b0;
        end else if (consumed) begin
            mem_busy = 1'b0;
        end else if (req.valid) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = mem_random ? int'(next_rand(mem_lcg) % 4) : 0;
            end
            if (mem_wait == 0) begin
                dresp.valid = 1'b1;
                dresp.rdata = dmem[req.addr[9:2]];
                if (req.write) begin
                    dmem[req.addr[9:2]] = req.wdata;
                    stores.push_back(req);
                end
            end else begin
                mem_wait = mem_wait - 1;
            end
        end
    end

    task automatic stop_on_error();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input core_pkg::word_t got,
                              input core_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_store(input int idx, input core_pkg::word_t addr,
                               input core_pkg::word_t data);
        if (idx >= stores.size()) begin
            $display("store number %0d never reached data memory", idx);
            stop_on_error();
        end
        check_word($sformatf("store[%0d].addr", idx), stores[idx].addr, addr);
        check_word($sformatf("store[%0d].wdata", idx), stores[idx].wdata, data);
    endtask

    task automatic check_exit(input logic exp);
        if (exit !== exp) begin
            $display("ERROR exit got %h expected %h", exit, exp);
            stop_on_error();
        end
    endtask

    // instruction encoders
    function automatic core_pkg::word_t enc_i(input core_pkg::word_t imm, input int rs1,
                                              input logic [2:0] f3, input int rd,
                                              input logic [6:0] op);
        return {imm[11:0], 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic core_pkg::word_t enc_r(input logic [6:0] f7, input int rs2,
                                              input int rs1, input logic [2:0] f3,
                                              input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic core_pkg::word_t enc_sw(input core_pkg::word_t imm, input int rs2,
                                               input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic core_pkg::word_t enc_b(input core_pkg::word_t imm, input int rs2,
                                              input int rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic core_pkg::word_t enc_jal(input core_pkg::word_t imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
    endfunction

    function automatic core_pkg::word_t enc_lui(input core_pkg::word_t imm, input int rd);
        return {imm[19:0], 5'(rd), 7'b0110111};
    endfunction

    function automatic core_pkg::word_t addi(input int rd, input int rs1,
                                             input core_pkg::word_t imm);
        return enc_i(imm, rs1, 3'b000, rd, 7'b0010011);
    endfunction

    function automatic core_pkg::word_t lw(input int rd, input int rs1,
                                           input core_pkg::word_t imm);
        return enc_i(imm, rs1, 3'b010, rd, 7'b0000011);
    endfunction

    task automatic begin_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0000_0013;
        end
        load_idx = 0;
    endtask

    task automatic put(input core_pkg::word_t inst);
        imem[load_idx] = inst;
        load_idx++;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        stores.delete();
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_value(32'(i * 4));
        end
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic run_program(input logic gaps, input logic rand_mem);
        int cycles;
        gaps_on = gaps;
        mem_random = rand_mem;
        apply_reset();
        check_exit(1'b0);
        cycles = 0;
        while (!exit) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 5000) begin
                $display("program did not reach ecall within 5000 cycles");
                stop_on_error();
            end
        end
        // let anything behind the ecall drain
        repeat (20) @(posedge clk);
        #1;
        check_exit(1'b1);
    endtask

    task automatic test_arith();
        core_pkg::word_t r [4:13];
        begin_program();
        put(enc_lui(32'h12345, 1));
        put(addi(1, 1, 32'h678));
        put(addi(2, 0, -32'sd5));
        put(enc_r(7'h00, 2, 1, 3'b000, 4));
        put(enc_r(7'h20, 1, 4, 3'b000, 5));
        put(enc_r(7'h00, 1, 4, 3'b111, 6));
        put(enc_r(7'h00, 6, 5, 3'b110, 7));
        put(enc_r(7'h00, 1, 7, 3'b100, 8));
        put(enc_r(7'h00, 1, 2, 3'b010, 9));
        put(enc_r(7'h00, 2, 1, 3'b010, 10));
        put(enc_i(32'h0ff, 8, 3'b111, 11, 7'b0010011));
        put(enc_i(32'hf00, 11, 3'b110, 12, 7'b0010011));
        put(enc_i(32'h555, 12, 3'b100, 13, 7'b0010011));
        for (int k = 0; k < 10; k++) begin
            put(enc_sw(32'h80 + 32'(4 * k), k + 4, 0));
        end
        put(32'h0000_0073);
        r[4] = 32'h1234_5678 + 32'hffff_fffb;
        r[5] = r[4] - 32'h1234_5678;
        r[6] = r[4] & 32'h1234_5678;
        r[7] = r[5] | r[6];
        r[8] = r[7] ^ 32'h1234_5678;
        r[9] = 32'd1;
        r[10] = 32'd0;
        r[11] = r[8] & 32'h0000_00ff;
        r[12] = r[11] | 32'hffff_ff00;
        r[13] = r[12] ^ 32'h0000_0555;
        run_program(1'b0, 1'b0);
        check_word("store count", 32'(stores.size()), 32'd10);
        for (int k = 0; k < 10; k++) begin
            check_store(k, 32'h80 + 32'(4 * k), r[k + 4]);
        end
    endtask

    task automatic load_use_program();
        begin_program();
        put(lw(1, 0, 32'h40));
        put(addi(2, 1, 32'd7));
        put(enc_sw(32'h80, 2, 0));
        put(lw(4, 0, 32'h44));
        put(enc_r(7'h00, 1, 4, 3'b000, 5));
        put(enc_sw(32'h84, 5, 0));
        put(lw(6, 0, 32'h84));
        put(enc_r(7'h00, 4, 6, 3'b100, 7));
        put(enc_sw(32'h88, 7, 0));
        put(32'h0000_0073);
    endtask

    task automatic test_load_use();
        core_pkg::word_t a;
        core_pkg::word_t b;
        load_use_program();
        a = fill_value(32'h40);
        b = fill_value(32'h44);
        run_program(1'b0, 1'b1);
        check_word("store count", 32'(stores.size()), 32'd3);
        check_store(0, 32'h80, a + 32'd7);
        check_store(1, 32'h84, a + b);
        check_store(2, 32'h88, (a + b) ^ b);
        ref_stores = stores;
    endtask

    task automatic test_branches();
        begin_program();
        put(addi(30, 0, 32'h7ad));
        put(addi(1, 0, 32'd5));
        put(addi(2, 0, 32'd5));
        put(enc_b(32'd12, 2, 1, 3'b000));
        put(enc_sw(32'h80, 30, 0));
        put(enc_sw(32'h80, 30, 0));
        put(enc_b(32'd12, 2, 1, 3'b001));
        put(enc_sw(32'h90, 1, 0));
        put(enc_b(32'd12, 0, 1, 3'b001));
        put(enc_sw(32'h80, 30, 0));
        put(enc_sw(32'h80, 30, 0));
        put(enc_b(32'd8, 0, 1, 3'b000));
        put(enc_jal(32'd12, 5));
        put(enc_sw(32'h80, 30, 0));
        put(enc_sw(32'h80, 30, 0));
        put(enc_sw(32'h94, 5, 0));
        put(addi(6, 0, 32'd80));
        put(enc_i(32'd0, 6, 3'b000, 7, 7'b1100111));
        put(enc_sw(32'h80, 30, 0));
        put(enc_sw(32'h80, 30, 0));
        put(enc_sw(32'h98, 7, 0));
        put(32'h0000_0073);
        run_program(1'b0, 1'b1);
        foreach (stores[i]) begin
            if (stores[i].wdata == 32'h7ad) begin
                $display("a wrong-path store reached memory at %h", stores[i].addr);
                stop_on_error();
            end
        end
        check_word("store count", 32'(stores.size()), 32'd3);
        check_store(0, 32'h90, 32'd5);
        // links are pc + 4 of the jal at 48 and the jalr at 68
        check_store(1, 32'h94, 32'd52);
        check_store(2, 32'h98, 32'd72);
    endtask

    task automatic test_exit();
        begin_program();
        put(addi(3, 0, 32'h123));
        put(enc_lui(32'habcde, 3));
        put(addi(3, 3, 32'h111));
        put(32'h0000_0073);
        // at most five instructions behind the ecall enter before exit stops fetch
        load_idx = 9;
        put(enc_sw(32'h80, 3, 0));
        put(enc_sw(32'h84, 3, 0));
        run_program(1'b1, 1'b1);
        check_word("gp", gp, 32'habcd_e111);
        check_word("store count", 32'(stores.size()), 32'd0);
    endtask

    task automatic test_gaps_slow();
        load_use_program();
        run_program(1'b1, 1'b1);
        check_word("store count", 32'(stores.size()), 32'(ref_stores.size()));
        foreach (ref_stores[i]) begin
            check_store(i, ref_stores[i].addr, ref_stores[i].wdata);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        iresp = '0;
        dresp = '0;
        fetch_pc = core_pkg::reset_pc;
        gap_lcg = 32'd25692;
        mem_lcg = 32'd25692;
        gaps_on = 1'b0;
        mem_random = 1'b0;
        mem_busy = 1'b0;
        mem_wait = 0;
        load_idx = 0;
        test_arith();
        test_load_use();
        test_branches();
        test_exit();
        test_gaps_slow();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* dv/core_chk.sv */
`timescale 1ns/1ps

module core_chk (
    input logic                 clk,
    input logic                 reset,
    input core_pkg::fetch_req_t ireq,
    input core_pkg::mem_req_t   dreq,
    input core_pkg::mem_resp_t  dresp,
    input logic                 exit
);

    // request held until the response cycle
    assert property (@(posedge clk) disable iff (reset)
        dreq.valid && !dresp.valid |=> $stable(dreq))
        else $error("dreq changed while waiting for dresp");

    // redirect is a single-cycle pulse
    assert property (@(posedge clk) disable iff (reset)
        ireq.valid |=> !ireq.valid)
        else $error("ireq.valid high for more than one cycle");

    assert property (@(posedge clk) disable iff (reset)
        exit |=> exit)
        else $error("exit fell after being set");

endmodule

bind core core_chk core_chk_inst (
    .clk   (clk),
    .reset (reset),
    .ireq  (ireq),
    .dreq  (dreq),
    .dresp (dresp),
    .exit  (exit)
);

/* source/core.sv */
`timescale 1ns/1ps

module core (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::fetch_resp_t iresp,
    output logic                  iresp_ready,
    output core_pkg::fetch_req_t  ireq,
    output core_pkg::mem_req_t    dreq,
    input  core_pkg::mem_resp_t   dresp,
    output core_pkg::word_t       gp,
    output logic                  exit
);

    logic id_valid;
    logic ds_valid;
    logic exe_valid;
    logic mem_valid;
    logic wb_valid;
    core_pkg::stage_t id_reg;
    core_pkg::stage_t ds_reg;
    core_pkg::stage_t exe_reg;
    core_pkg::stage_t mem_reg;
    core_pkg::stage_t wb_reg;
    core_pkg::word_t wb_load_data;

    core_pkg::stage_t id_out;
    core_pkg::stage_t ds_out;
    core_pkg::stage_t exe_out;
    core_pkg::stage_t mem_out;
    core_pkg::word_t mem_load_data;
    core_pkg::word_t rf_rdata1;
    core_pkg::word_t rf_rdata2;
    core_pkg::word_t wb_wdata;
    core_pkg::fwd_t exe_fwd;
    core_pkg::fwd_t mem_fwd;
    core_pkg::fwd_t wb_fwd;

    logic hazard_stall;
    logic unit_stall;
    logic mem_stall;
    logic exe_stall;
    logic ds_stall;
    logic id_stall;

    logic branch_taken;
    core_pkg::word_t branch_target;
    core_pkg::word_t successor;
    logic mispredict;
    logic redirect_q;
    core_pkg::word_t redirect_addr;

    // stall chain from the back of the pipe forward
    assign mem_stall = mem_valid && unit_stall;
    // a branch needs the next pc in data select before it can be checked
    assign exe_stall = exe_valid && (mem_stall ||
                       (exe_reg.ctrl.br_kind != core_pkg::br_none && !ds_valid));
    assign ds_stall = ds_valid && (exe_stall || hazard_stall);
    assign id_stall = id_valid && ds_stall;

    assign iresp_ready = !exit && !id_stall;

    assign successor = branch_taken ? branch_target : exe_reg.pc + 32'd4;
    assign mispredict = exe_valid && ds_valid && !exe_stall && ds_reg.pc != successor;

    // registered so execute never drives the queue directly
    assign ireq = '{valid: redirect_q, addr: redirect_addr};

    assign exe_fwd = '{valid:       exe_valid && exe_reg.ctrl.wb_en,
                       can_forward: 1'b0,
                       addr:        exe_reg.ctrl.rd,
                       data:        '0};
    // loads are still in flight here
    assign mem_fwd = '{valid:       mem_valid && mem_reg.ctrl.wb_en,
                       can_forward: mem_reg.ctrl.wb_sel != core_pkg::wb_mem,
                       addr:        mem_reg.ctrl.rd,
                       data:        (mem_reg.ctrl.wb_sel == core_pkg::wb_pc4) ?
                                    mem_reg.pc + 32'd4 : mem_reg.alu_out};
    assign wb_fwd = '{valid:       wb_valid && wb_reg.ctrl.wb_en,
                      can_forward: 1'b1,
                      addr:        wb_reg.ctrl.rd,
                      data:        wb_wdata};

    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
            ds_valid <= 1'b0;
            exe_valid <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid <= 1'b0;
            redirect_q <= 1'b0;
        end else begin
            // decode is flushed twice, fetch output in the redirect cycle is stale
            if (mispredict || redirect_q) begin
                id_valid <= 1'b0;
            end else if (!id_stall) begin
                id_valid <= iresp.valid && iresp_ready;
            end
            if (mispredict) begin
                ds_valid <= 1'b0;
            end else if (!ds_stall) begin
                ds_valid <= id_valid;
            end
            if (!exe_stall) begin
                exe_valid <= ds_valid && !ds_stall && !mispredict;
            end
            if (!mem_stall) begin
                mem_valid <= exe_valid && !exe_stall;
            end
            wb_valid <= mem_valid && !mem_stall;
            redirect_q <= mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (!id_stall) begin
            id_reg <= '{pc: iresp.addr, inst: iresp.inst, default: '0};
        end
        if (!ds_stall) begin
            ds_reg <= id_out;
        end
        if (!exe_stall) begin
            exe_reg <= ds_out;
        end
        if (!mem_stall) begin
            mem_reg <= exe_out;
        end
        wb_reg <= mem_out;
        wb_load_data <= mem_load_data;
        redirect_addr <= successor;
    end

    decode_stage decode_inst (
        .in  (id_reg),
        .out (id_out)
    );

    data_select_stage data_select_inst (
        .in             (ds_reg),
        .regfile_rdata1 (rf_rdata1),
        .regfile_rdata2 (rf_rdata2),
        .exe_fwd        (exe_fwd),
        .mem_fwd        (mem_fwd),
        .wb_fwd         (wb_fwd),
        .out            (ds_out),
        .hazard_stall   (hazard_stall)
    );

    execute_stage execute_inst (
        .in            (exe_reg),
        .out           (exe_out),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    memory_stage memory_inst (
        .clk        (clk),
        .reset      (reset),
        .valid      (mem_valid),
        .in         (mem_reg),
        .dreq       (dreq),
        .dresp      (dresp),
        .out        (mem_out),
        .load_data  (mem_load_data),
        .unit_stall (unit_stall)
    );

    write_back_stage write_back_inst (
        .clk       (clk),
        .reset     (reset),
        .valid     (wb_valid),
        .in        (wb_reg),
        .load_data (wb_load_data),
        .rs1       (ds_reg.ctrl.rs1),
        .rs2       (ds_reg.ctrl.rs2),
        .rdata1    (rf_rdata1),
        .rdata2    (rf_rdata2),
        .wdata     (wb_wdata),
        .gp        (gp),
        .exit      (exit)
    );

endmodule

/* source/write_back_stage.sv */
`timescale 1ns/1ps

module write_back_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid,
    input  core_pkg::stage_t    in,
    input  core_pkg::word_t     load_data,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    output core_pkg::word_t     rdata1,
    output core_pkg::word_t     rdata2,
    output core_pkg::word_t     wdata,
    output core_pkg::word_t     gp,
    output logic                exit
);

    // x0 is not stored
    core_pkg::word_t regs [1:31];
    logic wen;

    always_comb begin
        case (in.ctrl.wb_sel)
            core_pkg::wb_mem: wdata = load_data;
            core_pkg::wb_pc4: wdata = in.pc + 32'd4;
            default:          wdata = in.alu_out;
        endcase
    end

    assign wen = valid && in.ctrl.wb_en && in.ctrl.rd != '0;

    always_ff @(posedge clk) begin
        if (wen) begin
            regs[in.ctrl.rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];
    assign gp = regs[core_pkg::gp_index];

    // sticky once ecall retires
    always_ff @(posedge clk) begin
        if (reset) begin
            exit <= 1'b0;
        end else if (valid && in.ctrl.exit) begin
            exit <= 1'b1;
        end
    end

endmodule

/* source/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  core_pkg::stage_t     in,
    output core_pkg::mem_req_t   dreq,
    input  core_pkg::mem_resp_t  dresp,
    output core_pkg::stage_t     out,
    output core_pkg::word_t      load_data,
    output logic                 unit_stall
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_done
    } state_e;

    state_e state;
    logic access;

    assign access = valid && in.ctrl.mem_op != core_pkg::mem_none;

    // request stays up from first cycle until the response
    assign unit_stall = (state == st_idle && access) || state == st_wait;

    assign dreq = '{valid: unit_stall,
                    write: in.ctrl.mem_op == core_pkg::mem_store,
                    addr:  in.alu_out,
                    wdata: in.store_data};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (access) state <= dresp.valid ? st_done : st_wait;
                st_wait: if (dresp.valid) state <= st_done;
                // instruction leaves this cycle
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (unit_stall && dresp.valid) begin
            load_data <= dresp.rdata;
        end
    end

    assign out = in;

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  core_pkg::stage_t in,
    output core_pkg::stage_t out,
    output logic             branch_taken,
    output core_pkg::word_t  branch_target
);

    core_pkg::word_t add_out;
    core_pkg::word_t alu_out;

    assign add_out = in.op1 + in.op2;

    always_comb begin
        case (in.ctrl.alu_op)
            core_pkg::alu_add:   alu_out = add_out;
            core_pkg::alu_sub:   alu_out = in.op1 - in.op2;
            core_pkg::alu_and:   alu_out = in.op1 & in.op2;
            core_pkg::alu_or:    alu_out = in.op1 | in.op2;
            core_pkg::alu_xor:   alu_out = in.op1 ^ in.op2;
            core_pkg::alu_slt:   alu_out = {31'b0, $signed(in.op1) < $signed(in.op2)};
            core_pkg::alu_copy2: alu_out = in.op2;
            default:             alu_out = add_out;
        endcase
    end

    always_comb begin
        case (in.ctrl.br_kind)
            core_pkg::br_beq:  branch_taken = in.op1 == in.op2;
            core_pkg::br_bne:  branch_taken = in.op1 != in.op2;
            core_pkg::br_jal:  branch_taken = 1'b1;
            core_pkg::br_jalr: branch_taken = 1'b1;
            default:           branch_taken = 1'b0;
        endcase
    end

    // jumps reuse the adder, conditional branches compare registers
    assign branch_target = (in.ctrl.br_kind == core_pkg::br_beq ||
                            in.ctrl.br_kind == core_pkg::br_bne) ?
                           in.pc + in.ctrl.imm : {add_out[31:1], 1'b0};

    always_comb begin
        out = in;
        out.alu_out = alu_out;
    end

endmodule

/* source/data_select_stage.sv */
`timescale 1ns/1ps

module data_select_stage (
    input  core_pkg::stage_t in,
    input  core_pkg::word_t  regfile_rdata1,
    input  core_pkg::word_t  regfile_rdata2,
    input  core_pkg::fwd_t   exe_fwd,
    input  core_pkg::fwd_t   mem_fwd,
    input  core_pkg::fwd_t   wb_fwd,
    output core_pkg::stage_t out,
    output logic             hazard_stall
);

    logic [32:0] src1;
    logic [32:0] src2;

    function automatic logic hits(input core_pkg::fwd_t f, input core_pkg::reg_addr_t addr);
        return f.valid && f.addr == addr;
    endfunction

    // youngest producer wins, stall bit sits above the data word
    function automatic logic [32:0] select_source(
        input core_pkg::reg_addr_t addr,
        input core_pkg::word_t     rf_data,
        input core_pkg::fwd_t      exe_f,
        input core_pkg::fwd_t      mem_f,
        input core_pkg::fwd_t      wb_f
    );
        if (addr == '0) begin
            return {1'b0, 32'h0000_0000};
        end else if (hits(exe_f, addr)) begin
            return {!exe_f.can_forward, exe_f.data};
        end else if (hits(mem_f, addr)) begin
            return {!mem_f.can_forward, mem_f.data};
        end else if (hits(wb_f, addr)) begin
            return {!wb_f.can_forward, wb_f.data};
        end
        return {1'b0, rf_data};
    endfunction

    assign src1 = select_source(in.ctrl.rs1, regfile_rdata1, exe_fwd, mem_fwd, wb_fwd);
    assign src2 = select_source(in.ctrl.rs2, regfile_rdata2, exe_fwd, mem_fwd, wb_fwd);

    assign hazard_stall = src1[32] || src2[32];

    always_comb begin
        out = in;
        out.op1 = in.ctrl.op1_pc ? in.pc : src1[31:0];
        out.op2 = in.ctrl.op2_imm ? in.ctrl.imm : src2[31:0];
        // rs2 also carries the store data
        out.store_data = src2[31:0];
    end

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  core_pkg::stage_t in,
    output core_pkg::stage_t out
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    core_pkg::word_t imm_i;
    core_pkg::word_t imm_s;
    core_pkg::word_t imm_b;
    core_pkg::word_t imm_u;
    core_pkg::word_t imm_j;
    core_pkg::ctrl_t ctrl;

    assign opcode = in.inst[6:0];
    assign funct3 = in.inst[14:12];
    assign funct7 = in.inst[31:25];

    assign imm_i = {{20{in.inst[31]}}, in.inst[31:20]};
    assign imm_s = {{20{in.inst[31]}}, in.inst[31:25], in.inst[11:7]};
    assign imm_b = {{19{in.inst[31]}}, in.inst[31], in.inst[7], in.inst[30:25],
                    in.inst[11:8], 1'b0};
    assign imm_u = {in.inst[31:12], 12'h000};
    assign imm_j = {{11{in.inst[31]}}, in.inst[31], in.inst[19:12], in.inst[20],
                    in.inst[30:21], 1'b0};

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = core_pkg::alu_add;
        ctrl.br_kind = core_pkg::br_none;
        ctrl.mem_op = core_pkg::mem_none;
        ctrl.wb_sel = core_pkg::wb_alu;
        ctrl.rd = in.inst[11:7];
        case (opcode)
            7'b0110111: begin
                // lui passes the immediate through the alu
                ctrl.alu_op = core_pkg::alu_copy2;
                ctrl.op2_imm = 1'b1;
                ctrl.imm = imm_u;
                ctrl.wb_en = 1'b1;
            end
            7'b0010011: begin
                ctrl.rs1 = in.inst[19:15];
                ctrl.op2_imm = 1'b1;
                ctrl.imm = imm_i;
                ctrl.wb_en = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = core_pkg::alu_add;
                    3'b100: ctrl.alu_op = core_pkg::alu_xor;
                    3'b110: ctrl.alu_op = core_pkg::alu_or;
                    3'b111: ctrl.alu_op = core_pkg::alu_and;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            7'b0110011: begin
                ctrl.rs1 = in.inst[19:15];
                ctrl.rs2 = in.inst[24:20];
                ctrl.wb_en = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.alu_op = core_pkg::alu_add;
                    10'b0100000_000: ctrl.alu_op = core_pkg::alu_sub;
                    10'b0000000_100: ctrl.alu_op = core_pkg::alu_xor;
                    10'b0000000_110: ctrl.alu_op = core_pkg::alu_or;
                    10'b0000000_111: ctrl.alu_op = core_pkg::alu_and;
                    10'b0000000_010: ctrl.alu_op = core_pkg::alu_slt;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            7'b0000011: begin
                // only lw
                ctrl.rs1 = in.inst[19:15];
                ctrl.op2_imm = 1'b1;
                ctrl.imm = imm_i;
                ctrl.mem_op = core_pkg::mem_load;
                ctrl.wb_sel = core_pkg::wb_mem;
                ctrl.wb_en = 1'b1;
                ctrl.illegal = funct3 != 3'b010;
            end
            7'b0100011: begin
                ctrl.rs1 = in.inst[19:15];
                ctrl.rs2 = in.inst[24:20];
                ctrl.op2_imm = 1'b1;
                ctrl.imm = imm_s;
                ctrl.mem_op = core_pkg::mem_store;
                ctrl.illegal = funct3 != 3'b010;
            end
            7'b1100011: begin
                ctrl.rs1 = in.inst[19:15];
                ctrl.rs2 = in.inst[24:20];
                ctrl.imm = imm_b;
                case (funct3)
                    3'b000: ctrl.br_kind = core_pkg::br_beq;
                    3'b001: ctrl.br_kind = core_pkg::br_bne;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            7'b1101111: begin
                // target computed by the alu as pc + imm
                ctrl.op1_pc = 1'b1;
                ctrl.op2_imm = 1'b1;
                ctrl.imm = imm_j;
                ctrl.br_kind = core_pkg::br_jal;
                ctrl.wb_sel = core_pkg::wb_pc4;
                ctrl.wb_en = 1'b1;
            end
            7'b1100111: begin
                ctrl.rs1 = in.inst[19:15];
                ctrl.op2_imm = 1'b1;
                ctrl.imm = imm_i;
                ctrl.br_kind = core_pkg::br_jalr;
                ctrl.wb_sel = core_pkg::wb_pc4;
                ctrl.wb_en = 1'b1;
                ctrl.illegal = funct3 != 3'b000;
            end
            7'b1110011: begin
                ctrl.exit = in.inst == 32'h0000_0073;
                ctrl.illegal = in.inst != 32'h0000_0073;
            end
            default: ctrl.illegal = 1'b1;
        endcase
        // unsupported encodings become no-ops
        if (ctrl.illegal) begin
            ctrl.wb_en = 1'b0;
            ctrl.mem_op = core_pkg::mem_none;
            ctrl.br_kind = core_pkg::br_none;
        end
        out = in;
        out.ctrl = ctrl;
    end

endmodule

/* source/core_pkg.sv */
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // first fetch address after reset
    localparam word_t reset_pc = 32'h0000_0000;
    localparam reg_addr_t gp_index = 5'd3;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_copy2
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_jal,
        br_jalr
    } br_kind_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4
    } wb_sel_e;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_op_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      op1_pc;
        logic      op2_imm;
        br_kind_e  br_kind;
        mem_op_e   mem_op;
        logic      wb_en;
        wb_sel_e   wb_sel;
        reg_addr_t rd;
        // zero when the source is not read
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      exit;
        word_t     imm;
        logic      illegal;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
        ctrl_t ctrl;
        word_t op1;
        word_t op2;
        word_t store_data;
        word_t alu_out;
    } stage_t;

    typedef struct packed {
        logic      valid;
        logic      can_forward;
        reg_addr_t addr;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        logic  valid;
        word_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic  valid;
        word_t addr;
        word_t inst;
    } fetch_resp_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        word_t rdata;
    } mem_resp_t;

endpackage
